//--- design/sm83_cfg.svh
`ifndef SM83_CFG_SVH
`define SM83_CFG_SVH

// Bus and sequencer widths
`define SM83_DATA_W   8
`define SM83_ADDR_W   16
`define SM83_STEP_W   3

// Stack pointer value out of reset
`define SM83_SP_RESET 16'hFFFF

`endif

//--- design/sm83_pkg.sv
package sm83_pkg;

    // Opcode byte, matched against the wildcard patterns below with casez
    typedef logic [7:0] opcode_t;

    localparam opcode_t OP_NOP      = 8'b0000_0000;
    localparam opcode_t OP_LD_RR_NN = 8'b00??_0001;
    localparam opcode_t OP_INCDEC_R = 8'b00??_?10?;
    localparam opcode_t OP_LD_R_N   = 8'b00??_?110;
    localparam opcode_t OP_LD_HL_R  = 8'b0111_0???;
    localparam opcode_t OP_LD_R_HL  = 8'b01??_?110;
    localparam opcode_t OP_LD_R_R   = 8'b01??_????;
    localparam opcode_t OP_ALU_A_HL = 8'b10??_?110;
    localparam opcode_t OP_ALU_A_R  = 8'b10??_????;
    localparam opcode_t OP_ALU_A_N  = 8'b11??_?110;
    localparam opcode_t OP_JP_NN    = 8'b1100_0011;
    localparam opcode_t OP_LD_NN_A  = 8'b1110_1010;
    localparam opcode_t OP_LD_A_NN  = 8'b1111_1010;

    // Same order as opcode bits 5:3
    typedef enum logic [2:0] {
        ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC,
        ALU_AND, ALU_XOR, ALU_OR,  ALU_CP
    } alu_op_t;

    typedef struct packed {
        logic z;
        logic n;
        logic h;
        logic c;
    } flags_t;

    typedef enum logic [3:0] {
        R8_NONE = 4'd0,
        R8_Z, R8_W,
        R8_B, R8_C, R8_D, R8_E, R8_H, R8_L,
        R8_SPH, R8_SPL,
        R8_PCH, R8_PCL,
        R8_A,
        R8_MEM = 4'd15          // External memory, not a register
    } reg8_t;

    typedef enum logic [2:0] {
        R16_WZ, R16_BC, R16_DE, R16_HL, R16_SP, R16_PC
    } reg16_t;

    typedef enum logic {ACC_A, ACC_DB} acc_sel_t;

    typedef enum logic {ARG_DB, ARG_ONE} arg_sel_t;

    typedef enum logic {R_WB_DB, R_WB_ALU} r_wb_t;

    typedef enum logic [1:0] {
        RR_WB_NONE, RR_WB_IDU, RR_WB_WZ
    } rr_wb_t;

endpackage

//--- design/ctrl_if.sv
`timescale 1ns/1ps

interface ctrl_if;
    import sm83_pkg::*;

    logic     done;         // Last step, fetch next opcode
    reg16_t   s_ab;         // Address bus source pair
    reg8_t    s_db;         // Data bus source
    reg8_t    t_db;         // 8-bit writeback target
    r_wb_t    s_r_wb;
    alu_op_t  alu_op;
    acc_sel_t s_acc;
    arg_sel_t s_arg;
    logic     idu_dec;      // Decrement instead of increment
    rr_wb_t   s_rr_wb;
    reg16_t   t_rr_wb;
    logic     wr_pc;        // PC takes the IDU result

    modport decoder (
        output done, s_ab, s_db, t_db, s_r_wb, alu_op,
               s_acc, s_arg, idu_dec, s_rr_wb, t_rr_wb, wr_pc
    );

    modport datapath (
        input done, s_ab, s_db, t_db, s_r_wb, alu_op,
              s_acc, s_arg, idu_dec, s_rr_wb, t_rr_wb, wr_pc
    );

endinterface

//--- design/step_sequencer.sv
`timescale 1ns/1ps
`include "sm83_cfg.svh"

module step_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    done,
    input  logic [`SM83_DATA_W-1:0] d_bus,
    output sm83_pkg::opcode_t       ir,
    output logic [`SM83_STEP_W-1:0] step
);
    import sm83_pkg::*;

    // The done step also fetches, so the next opcode is latched on the same edge
    always_ff @(posedge clk) begin
        if (!rst) begin
            ir   <= OP_NOP;         // NOP step 0 fetches address 0
            step <= '0;
        end else if (done) begin
            ir   <= opcode_t'(d_bus);
            step <= '0;
        end else begin
            step <= step + 1'b1;
        end
    end

    // Decoder must end every kept instruction within four steps
    a_step_range: assert property (@(posedge clk) disable iff (!rst) step <= 3)
        else $error("step counter ran past 3, ir=%h", ir);

endmodule

//--- design/micro_decoder.sv
`timescale 1ns/1ps
`include "sm83_cfg.svh"

module micro_decoder (
    input  sm83_pkg::opcode_t       ir,
    input  logic [`SM83_STEP_W-1:0] step,
    ctrl_if.decoder                 ctrl
);
    import sm83_pkg::*;

    localparam logic [`SM83_STEP_W-1:0] S0    = 0;
    localparam logic [`SM83_STEP_W-1:0] S1    = 1;
    localparam logic [`SM83_STEP_W-1:0] S2    = 2;
    localparam logic [`SM83_STEP_W-1:0] S_ANY = 'z;

    // (HL) forms that alias kept patterns but are not implemented
    localparam opcode_t OP_HALT      = 8'b0111_0110;
    localparam opcode_t OP_LD_HL_N   = 8'b0011_0110;
    localparam opcode_t OP_INCDEC_HL = 8'b0011_010?;

    reg8_t  r8_dst;
    reg8_t  r8_src;
    reg8_t  alu_tgt;
    reg16_t r16;

    function automatic reg8_t r8_idx(input logic [2:0] f);
        case (f)
            3'd0:    return R8_B;
            3'd1:    return R8_C;
            3'd2:    return R8_D;
            3'd3:    return R8_E;
            3'd4:    return R8_H;
            3'd5:    return R8_L;
            3'd6:    return R8_MEM;
            default: return R8_A;
        endcase
    endfunction

    always_comb begin
        r8_dst  = r8_idx(ir[5:3]);
        r8_src  = r8_idx(ir[2:0]);
        alu_tgt = (ir[5:3] == 3'd7) ? R8_NONE : R8_A;   // CP drops its result
        case (ir[5:4])
            2'd0:    r16 = R16_BC;
            2'd1:    r16 = R16_DE;
            2'd2:    r16 = R16_HL;
            default: r16 = R16_SP;
        endcase
    end

    always_comb begin
        // Idle step, nothing written
        ctrl.done    = 1'b0;
        ctrl.s_ab    = R16_PC;
        ctrl.s_db    = R8_NONE;
        ctrl.t_db    = R8_NONE;
        ctrl.s_r_wb  = R_WB_DB;
        ctrl.alu_op  = alu_op_t'(ir[5:3]);
        ctrl.s_acc   = ACC_A;
        ctrl.s_arg   = ARG_DB;
        ctrl.idu_dec = 1'b0;
        ctrl.s_rr_wb = RR_WB_NONE;
        ctrl.t_rr_wb = R16_WZ;
        ctrl.wr_pc   = 1'b0;

        casez ({ir, step})
            {OP_HALT, S_ANY}, {OP_LD_HL_N, S_ANY}, {OP_INCDEC_HL, S_ANY}: begin
                ctrl.done  = 1'b1;          // Skip as a NOP
                ctrl.wr_pc = 1'b1;
            end
            {OP_LD_RR_NN, S0}, {OP_JP_NN, S0}, {OP_LD_NN_A, S0},
            {OP_LD_A_NN, S0}, {OP_LD_R_N, S0}, {OP_ALU_A_N, S0}: begin
                ctrl.wr_pc = 1'b1;          // Z <- [PC]
                ctrl.s_db  = R8_MEM;
                ctrl.t_db  = R8_Z;
            end
            {OP_LD_RR_NN, S1}, {OP_JP_NN, S1}, {OP_LD_NN_A, S1}, {OP_LD_A_NN, S1}: begin
                ctrl.wr_pc = 1'b1;          // W <- [PC]
                ctrl.s_db  = R8_MEM;
                ctrl.t_db  = R8_W;
            end
            {OP_LD_RR_NN, S2}: begin
                ctrl.done    = 1'b1;
                ctrl.wr_pc   = 1'b1;
                ctrl.s_rr_wb = RR_WB_WZ;
                ctrl.t_rr_wb = r16;
            end
            {OP_JP_NN, S2}: begin
                ctrl.s_ab    = R16_WZ;
                ctrl.s_rr_wb = RR_WB_WZ;    // Next step fetches at the target
                ctrl.t_rr_wb = R16_PC;
            end
            {OP_LD_NN_A, S2}: begin
                ctrl.s_ab = R16_WZ;
                ctrl.s_db = R8_A;
                ctrl.t_db = R8_MEM;
            end
            {OP_LD_A_NN, S2}: begin
                ctrl.s_ab = R16_WZ;
                ctrl.s_db = R8_MEM;
                ctrl.t_db = R8_A;
            end
            {OP_INCDEC_R, S0}: begin
                ctrl.done   = 1'b1;
                ctrl.wr_pc  = 1'b1;
                ctrl.s_db   = r8_dst;
                ctrl.t_db   = r8_dst;
                ctrl.s_acc  = ACC_DB;
                ctrl.s_arg  = ARG_ONE;
                ctrl.s_r_wb = R_WB_ALU;
                ctrl.alu_op = ir[0] ? ALU_SUB : ALU_ADD;
            end
            {OP_LD_HL_R, S0}: begin
                ctrl.s_ab = R16_HL;
                ctrl.s_db = r8_src;
                ctrl.t_db = R8_MEM;
            end
            {OP_LD_R_HL, S0}, {OP_ALU_A_HL, S0}: begin
                ctrl.s_ab = R16_HL;         // Z <- [HL]
                ctrl.s_db = R8_MEM;
                ctrl.t_db = R8_Z;
            end
            {OP_LD_R_N, S1}, {OP_LD_R_HL, S1}: begin
                ctrl.done  = 1'b1;
                ctrl.wr_pc = 1'b1;
                ctrl.s_db  = R8_Z;
                ctrl.t_db  = r8_dst;
            end
            {OP_LD_R_R, S0}: begin
                ctrl.done  = 1'b1;
                ctrl.wr_pc = 1'b1;
                ctrl.s_db  = r8_src;
                ctrl.t_db  = r8_dst;
            end
            {OP_ALU_A_HL, S1}, {OP_ALU_A_N, S1}: begin
                ctrl.done   = 1'b1;
                ctrl.wr_pc  = 1'b1;
                ctrl.s_db   = R8_Z;
                ctrl.t_db   = alu_tgt;
                ctrl.s_r_wb = R_WB_ALU;
            end
            {OP_ALU_A_R, S0}: begin
                ctrl.done   = 1'b1;
                ctrl.wr_pc  = 1'b1;
                ctrl.s_db   = r8_src;
                ctrl.t_db   = alu_tgt;
                ctrl.s_r_wb = R_WB_ALU;
            end
            default: begin
                // NOP, final fetch steps and unknown bytes
                ctrl.done  = 1'b1;
                ctrl.wr_pc = 1'b1;
            end
        endcase
    end

endmodule

//--- design/alu.sv
`timescale 1ns/1ps
`include "sm83_cfg.svh"

module alu (
    input  sm83_pkg::alu_op_t       op,
    input  logic [`SM83_DATA_W-1:0] acc,
    input  logic [`SM83_DATA_W-1:0] arg,
    input  logic                    c_in,
    output logic [`SM83_DATA_W-1:0] res,
    output sm83_pkg::flags_t        f_out
);
    import sm83_pkg::*;

    localparam int NW = `SM83_DATA_W / 2;

    logic [`SM83_DATA_W-1:0] addend;
    logic [NW-1:0]           sum_lo;
    logic [NW-1:0]           sum_hi;
    logic                    sub;
    logic                    logic_op;
    logic                    carry;
    logic                    half;
    logic                    c_out;

    always_comb begin
        sub      = op inside {ALU_SUB, ALU_SBC, ALU_CP};
        logic_op = op inside {ALU_AND, ALU_XOR, ALU_OR};
        addend   = sub ? ~arg : arg;     // a - b as a + ~b + 1
        case (op)
            ALU_ADC, ALU_SBC: carry = c_in;
            ALU_SUB, ALU_CP:  carry = 1'b1;
            default:          carry = 1'b0;
        endcase

        // Two nibble adders, half carry falls out of the low one
        {half, sum_lo}  = acc[NW-1:0] + addend[NW-1:0] + carry;
        {c_out, sum_hi} = acc[`SM83_DATA_W-1:NW] + addend[`SM83_DATA_W-1:NW] + half;

        case (op)
            ALU_AND: res = acc & arg;
            ALU_XOR: res = acc ^ arg;
            ALU_OR:  res = acc | arg;
            default: res = {sum_hi, sum_lo};
        endcase

        // C is the raw adder carry, so a subtract sets it when nothing is borrowed
        if (logic_op) f_out = {res == '0, 3'b000};
        else          f_out = {res == '0, sub, half, c_out};
    end

endmodule

//--- design/datapath.sv
`timescale 1ns/1ps
`include "sm83_cfg.svh"

module datapath (
    input  logic                    clk,
    input  logic                    rst,
    ctrl_if.datapath                ctrl,
    input  logic [`SM83_DATA_W-1:0] d_in,
    output logic [`SM83_ADDR_W-1:0] addr,
    output logic [`SM83_DATA_W-1:0] d_out,
    output logic                    write,
    output logic [`SM83_DATA_W-1:0] d_bus
);
    import sm83_pkg::*;

    localparam int RF_LO = int'(R8_Z);
    localparam int RF_HI = int'(R8_A);

    logic [`SM83_DATA_W-1:0] rf [RF_LO:RF_HI];
    flags_t                  flags;

    logic [`SM83_DATA_W-1:0] db;            // Internal data bus
    logic [`SM83_DATA_W-1:0] acc;
    logic [`SM83_DATA_W-1:0] arg;
    logic [`SM83_DATA_W-1:0] alu_res;
    logic [`SM83_DATA_W-1:0] r_wb;
    logic [`SM83_ADDR_W-1:0] idu_res;
    logic [`SM83_ADDR_W-1:0] rr_wb;
    flags_t                  alu_f;

    always_comb begin
        case (ctrl.s_db)
            R8_MEM:  db = d_in;
            R8_NONE: db = '0;
            default: db = rf[ctrl.s_db];
        endcase

        case (ctrl.s_ab)
            R16_WZ:  addr = {rf[R8_W], rf[R8_Z]};
            R16_BC:  addr = {rf[R8_B], rf[R8_C]};
            R16_DE:  addr = {rf[R8_D], rf[R8_E]};
            R16_HL:  addr = {rf[R8_H], rf[R8_L]};
            R16_SP:  addr = {rf[R8_SPH], rf[R8_SPL]};
            default: addr = {rf[R8_PCH], rf[R8_PCL]};
        endcase

        case (ctrl.s_rr_wb)
            RR_WB_IDU: rr_wb = idu_res;
            RR_WB_WZ:  rr_wb = {rf[R8_W], rf[R8_Z]};
            default:   rr_wb = '0;
        endcase
    end

    // Increment/decrement unit works on whatever the address bus shows
    assign idu_res = ctrl.idu_dec ? addr - 1'b1 : addr + 1'b1;

    assign acc  = (ctrl.s_acc == ACC_DB) ? db : rf[R8_A];
    assign arg  = (ctrl.s_arg == ARG_ONE) ? `SM83_DATA_W'(1) : db;
    assign r_wb = (ctrl.s_r_wb == R_WB_ALU) ? alu_res : db;

    alu u_alu (
        .op    (ctrl.alu_op),
        .acc   (acc),
        .arg   (arg),
        .c_in  (flags.c),
        .res   (alu_res),
        .f_out (alu_f)
    );

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int k = RF_LO; k <= RF_HI; k++) begin
                rf[k] <= '0;
            end
            {rf[R8_SPH], rf[R8_SPL]} <= `SM83_SP_RESET;
            flags <= '0;
        end else begin
            if (ctrl.wr_pc)
                {rf[R8_PCH], rf[R8_PCL]} <= idu_res;
            if (ctrl.s_rr_wb != RR_WB_NONE) begin
                case (ctrl.t_rr_wb)
                    R16_WZ:  {rf[R8_W], rf[R8_Z]} <= rr_wb;
                    R16_BC:  {rf[R8_B], rf[R8_C]} <= rr_wb;
                    R16_DE:  {rf[R8_D], rf[R8_E]} <= rr_wb;
                    R16_HL:  {rf[R8_H], rf[R8_L]} <= rr_wb;
                    R16_SP:  {rf[R8_SPH], rf[R8_SPL]} <= rr_wb;
                    default: {rf[R8_PCH], rf[R8_PCL]} <= rr_wb;
                endcase
            end
            if (ctrl.t_db != R8_NONE && ctrl.t_db != R8_MEM)
                rf[ctrl.t_db] <= r_wb;
            if (ctrl.s_r_wb == R_WB_ALU)
                flags <= alu_f;     // Loads leave flags alone
        end
    end

    assign d_out = db;
    assign write = (ctrl.t_db == R8_MEM);
    assign d_bus = d_in;            // Opcode byte read at the fetch address

    // A step never reads and writes memory at once
    a_no_mem_to_mem: assert property (
        @(posedge clk) disable iff (!rst) !(write && ctrl.s_db == R8_MEM))
        else $error("write with memory as data source, addr=%h", addr);

endmodule

//--- design/sm83_core.sv
`timescale 1ns/1ps
`include "sm83_cfg.svh"

module sm83_core (
    input  logic                    clk,
    input  logic                    rst,
    output logic [`SM83_ADDR_W-1:0] addr,
    input  logic [`SM83_DATA_W-1:0] d_in,
    output logic [`SM83_DATA_W-1:0] d_out,
    output logic                    write
);
    import sm83_pkg::*;

    opcode_t                 ir;
    logic [`SM83_STEP_W-1:0] step;
    logic [`SM83_DATA_W-1:0] d_bus;

    ctrl_if u_ctrl ();

    step_sequencer u_seq (
        .clk   (clk),
        .rst   (rst),
        .done  (u_ctrl.done),
        .d_bus (d_bus),
        .ir    (ir),
        .step  (step)
    );

    micro_decoder u_dec (
        .ir   (ir),
        .step (step),
        .ctrl (u_ctrl.decoder)
    );

    datapath u_dp (
        .clk   (clk),
        .rst   (rst),
        .ctrl  (u_ctrl.datapath),
        .d_in  (d_in),
        .addr  (addr),
        .d_out (d_out),
        .write (write),
        .d_bus (d_bus)
    );

endmodule

//--- verification/sm83_model.svh
`ifndef SM83_MODEL_SVH
`define SM83_MODEL_SVH

// Instruction-level model of the core, uses N_INSTR of the including testbench

logic [7:0]  m_reg [0:7];               // Indexed by opcode register field, 6 unused
logic [3:0]  m_flags;                   // Z N H C
logic [7:0]  ref_mem [0:65535];
logic [31:0] rng_state = 32'd56;
logic [15:0] gen_ptr;
logic [15:0] code_end;
logic [15:0] exp_addr [$];              // Expected bus trace, one entry per clock
bit          exp_write [$];
logic [7:0]  exp_data [$];

function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

function automatic logic [7:0] fill_byte(input logic [15:0] a);
    return a[15:8] ^ {a[6:0], a[7]} ^ 8'hA5;
endfunction

// H and L only as sources, so HL stays inside the RAM window
function automatic logic [2:0] reg_field(input bit dst);
    logic [2:0] f;
    f = 3'(xorshift32() % (dst ? 5 : 7));
    if (f == 3'd6 || (dst && f == 3'd4))
        f = 3'd7;
    return f;
endfunction

function automatic int op_len(input logic [7:0] op);
    casez (op)
        8'b00??_0001, 8'hC3, 8'hEA, 8'hFA: return 3;
        8'b00??_?110, 8'b11??_?110:        return 2;
        default:                           return 1;
    endcase
endfunction

// Subtracts add the inverted argument, carry-in forced or taken from C
function automatic logic [7:0] alu_ref(input logic [2:0] op, input logic [7:0] a,
                                       input logic [7:0] b);
    logic       sub;
    logic       cy;
    logic [7:0] bx;
    logic [8:0] sum;
    logic [7:0] res;
    sub = (op == 3'd2) || (op == 3'd3) || (op == 3'd7);
    bx  = sub ? ~b : b;
    cy  = (op == 3'd1 || op == 3'd3) ? m_flags[0] : (op == 3'd2 || op == 3'd7);
    sum = a + bx + cy;
    case (op)
        3'd4:    res = a & b;
        3'd5:    res = a ^ b;
        3'd6:    res = a | b;
        default: res = sum[7:0];
    endcase
    if (op >= 3'd4 && op <= 3'd6)
        m_flags = {res == 8'h00, 3'b000};
    else
        m_flags = {res == 8'h00, sub, (a[3:0] + bx[3:0] + cy) > 5'd15, sum[8]};
    return res;
endfunction

task automatic alu_to_a(input logic [2:0] op, input logic [7:0] b);
    logic [7:0] res;
    res = alu_ref(op, m_reg[7], b);
    if (op != 3'd7)
        m_reg[7] = res;                 // CP keeps A
endtask

task automatic emit(input logic [7:0] b);
    ref_mem[gen_ptr] = b;
    gen_ptr = gen_ptr + 16'd1;
endtask

task automatic push_cycle(input logic [15:0] a, input bit w, input logic [7:0] d);
    exp_addr.push_back(a);
    exp_write.push_back(w);
    exp_data.push_back(d);
endtask

task gen_program;
    logic [15:0] start_addr [0:N_INSTR];
    logic [15:0] jp_at [0:N_INSTR-1];
    logic [7:0]  op;
    logic [7:0]  b1;
    logic [7:0]  b2;
    logic [2:0]  d;
    logic [2:0]  s;
    logic [2:0]  o;
    logic [3:0]  kind;
    int          k;
    for (int a = 0; a < 65536; a++)
        ref_mem[a] = fill_byte(16'(a));
    gen_ptr = 16'h0000;
    for (int i = 0; i < N_INSTR; i++) begin
        kind = (i == 0) ? 4'd10 : 4'(xorshift32());    // First one sets HL
        d    = reg_field(1'b1);
        s    = reg_field(1'b0);
        o    = (i == 0) ? 3'd2 : 3'(xorshift32());
        b1   = 8'(xorshift32());
        b2   = (kind == 4'd10 && o[1:0] != 2'd2) ? 8'(xorshift32()) : 8'hC0;
        case (kind)
            4'd0:         op = 8'h00;
            4'd1:         op = {2'b00, d, 3'b110};
            4'd2:         op = {2'b01, d, s};
            4'd3:         op = {2'b01, d, 3'b110};
            4'd5, 4'd6:   op = {2'b10, o, s};
            4'd7:         op = {2'b10, o, 3'b110};
            4'd8:         op = {2'b11, o, 3'b110};
            4'd9:         op = {2'b00, d, 2'b10, o[0]};     // INC or DEC
            4'd10:        op = {2'b00, o[1:0], 4'b0001};
            4'd11, 4'd12: op = 8'hEA;
            4'd13:        op = 8'hFA;
            4'd14:        op = 8'hC3;
            default:      op = {5'b01110, s};               // LD (HL),r
        endcase
        start_addr[i] = gen_ptr;
        jp_at[i]      = (op == 8'hC3) ? gen_ptr + 16'd1 : 16'h0000;
        emit(op);
        if (op_len(op) > 1)
            emit(b1);
        if (op_len(op) > 2)
            emit(b2);
    end
    start_addr[N_INSTR] = gen_ptr;
    code_end = gen_ptr;
    // Jumps land one to four instructions ahead, at most on the code end
    for (int i = 0; i < N_INSTR; i++) begin
        if (jp_at[i] != 16'h0000) begin
            k = i + 1 + int'(xorshift32() % 4);
            if (k > N_INSTR)
                k = N_INSTR;
            ref_mem[jp_at[i]]         = start_addr[k][7:0];
            ref_mem[jp_at[i] + 16'd1] = start_addr[k][15:8];
        end
    end
endtask

task automatic run_model();
    logic [15:0] pc;
    logic [15:0] hl;
    logic [15:0] nn;
    logic [7:0]  op;
    for (int i = 0; i < 8; i++)
        m_reg[i] = 8'h00;
    m_flags = 4'h0;
    pc      = 16'h0000;
    push_cycle(pc, 1'b0, 8'h00);        // Fetch right out of reset
    while (pc != code_end) begin
        op = ref_mem[pc];
        pc = pc + 16'd1;
        hl = {m_reg[4], m_reg[5]};
        nn = {ref_mem[pc + 16'd1], ref_mem[pc]};
        if (op_len(op) > 1)
            push_cycle(pc, 1'b0, 8'h00);            // Immediate bytes in order
        if (op_len(op) > 2)
            push_cycle(pc + 16'd1, 1'b0, 8'h00);
        casez (op)
            8'b00??_0001: case (op[5:4])
                2'd0:    {m_reg[0], m_reg[1]} = nn;
                2'd1:    {m_reg[2], m_reg[3]} = nn;
                2'd2:    {m_reg[4], m_reg[5]} = nn;
                default: ;                          // SP never reaches the bus
            endcase
            8'b00??_?110: m_reg[op[5:3]] = ref_mem[pc];
            8'b00??_?10?: m_reg[op[5:3]] = alu_ref(op[0] ? 3'd2 : 3'd0, m_reg[op[5:3]], 8'h01);
            8'b0111_0???: begin
                push_cycle(hl, 1'b1, m_reg[op[2:0]]);
                ref_mem[hl] = m_reg[op[2:0]];
            end
            8'b01??_?110: begin
                push_cycle(hl, 1'b0, 8'h00);
                m_reg[op[5:3]] = ref_mem[hl];
            end
            8'b01??_????: m_reg[op[5:3]] = m_reg[op[2:0]];
            8'b10??_?110: begin
                push_cycle(hl, 1'b0, 8'h00);
                alu_to_a(op[5:3], ref_mem[hl]);
            end
            8'b10??_????: alu_to_a(op[5:3], m_reg[op[2:0]]);
            8'b11??_?110: alu_to_a(op[5:3], ref_mem[pc]);
            8'hC3:        push_cycle(nn, 1'b0, 8'h00);  // Target shows before the fetch
            8'hEA: begin
                push_cycle(nn, 1'b1, m_reg[7]);
                ref_mem[nn] = m_reg[7];
            end
            8'hFA: begin
                push_cycle(nn, 1'b0, 8'h00);
                m_reg[7] = ref_mem[nn];
            end
            default: ;                                  // NOP
        endcase
        pc = (op == 8'hC3) ? nn : pc + 16'(op_len(op) - 1);
        push_cycle(pc, 1'b0, 8'h00);    // Last step fetches the next opcode
    end
endtask

`endif

//--- verification/sm83_tb.sv
`timescale 1ns/1ps

module sm83_tb;

    localparam int N_INSTR    = 200;
    localparam int MAX_CYCLES = 4 * N_INSTR + 50;

    logic        clk;
    logic        rst;
    logic [15:0] addr;
    logic [7:0]  d_in;
    logic [7:0]  d_out;
    logic        write;
    logic [7:0]  mem [0:65535];
    int          errors;
    int          cycles;

    `include "sm83_model.svh"

    sm83_core UUT (
        .clk   (clk),
        .rst   (rst),
        .addr  (addr),
        .d_in  (d_in),
        .d_out (d_out),
        .write (write)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Memory takes the store at the edge that ends the step
    always @(posedge clk) begin
        if (rst && write)
            mem[addr] <= d_out;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, bus trace not finished", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic check_cycle(input int idx);
        if (addr !== exp_addr[idx]) begin
            $display("ERROR cycle %0d addr: got %h expected %h", idx, addr, exp_addr[idx]);
            errors++;
        end
        if (write !== exp_write[idx]) begin
            $display("ERROR cycle %0d write: got %h expected %h", idx, write, exp_write[idx]);
            errors++;
        end
        if (exp_write[idx] && d_out !== exp_data[idx]) begin
            $display("ERROR cycle %0d d_out: got %h expected %h", idx, d_out, exp_data[idx]);
            errors++;
        end
    endtask

    initial begin
        rst    = 1'b0;
        d_in   = 8'h00;
        errors = 0;
        cycles = 0;
        gen_program();
        for (int a = 0; a < 65536; a++)
            mem[a] = ref_mem[a];
        run_model();                    // Expected trace before the DUT runs
        $display("Program of %0d bytes, %0d bus cycles", code_end, exp_addr.size());

        // Reset held over five rising edges
        repeat (5) begin
            @(posedge clk);
            @(negedge clk);
            if (write !== 1'b0) begin
                $display("ERROR reset write: got %h expected 0", write);
                errors++;
            end
        end
        rst = 1'b1;

        // Each falling edge checks one trace entry and then drives d_in
        for (int i = 0; i < exp_addr.size(); i++) begin
            if (i > 0)
                @(negedge clk);
            check_cycle(i);
            d_in = mem[addr];
        end

        $display("Checked %0d cycles, %0d errors", exp_addr.size(), errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- sim.f
+incdir+design
+incdir+verification
design/sm83_pkg.sv
design/ctrl_if.sv
design/step_sequencer.sv
design/micro_decoder.sv
design/alu.sv
design/datapath.sv
design/sm83_core.sv
verification/sm83_tb.sv
